/* ex_pkg.sv */
package ex_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] flags_t;
  typedef logic [2:0]  aluk_t;
  typedef logic [1:0]  shk_t;
  typedef logic [1:0]  dsize_t;
  typedef logic [2:0]  reg_t;

  // data size codes
  localparam dsize_t DS_8  = 2'd0;
  localparam dsize_t DS_16 = 2'd1;
  localparam dsize_t DS_32 = 2'd2;

  // alu ops, x86 group-1 order
  localparam aluk_t ALUK_ADD = 3'd0;
  localparam aluk_t ALUK_OR  = 3'd1;
  localparam aluk_t ALUK_ADC = 3'd2;
  localparam aluk_t ALUK_SBB = 3'd3;
  localparam aluk_t ALUK_AND = 3'd4;
  localparam aluk_t ALUK_SUB = 3'd5;
  localparam aluk_t ALUK_XOR = 3'd6;
  localparam aluk_t ALUK_CMP = 3'd7;

  localparam shk_t SHK_SHL  = 2'd0;
  localparam shk_t SHK_SHR  = 2'd1;
  localparam shk_t SHK_SAR  = 2'd2;
  localparam shk_t SHK_PASS = 2'd3;

  // eflags bit positions
  localparam int FLAG_CF = 0;
  localparam int FLAG_PF = 2;
  localparam int FLAG_ZF = 6;
  localparam int FLAG_SF = 7;
  localparam int FLAG_OF = 11;

  function automatic word_t size_mask(input dsize_t ds);
    case (ds)
      DS_8:    size_mask = 32'h0000_00ff;
      DS_16:   size_mask = 32'h0000_ffff;
      DS_32:   size_mask = 32'hffff_ffff;
      default: size_mask = 32'hffff_ffff;
    endcase
  endfunction

  // index of the sign bit for a data size
  function automatic logic [4:0] sign_pos(input dsize_t ds);
    case (ds)
      DS_8:    sign_pos = 5'd7;
      DS_16:   sign_pos = 5'd15;
      default: sign_pos = 5'd31;
    endcase
  endfunction

endpackage

/* operand_select_ex.sv */
`timescale 1ns/1ps

module operand_select_ex (
  input  logic           use_c_as_b,
  input  ex_pkg::dsize_t dsize,
  input  ex_pkg::word_t  ex_a,
  input  ex_pkg::word_t  ex_b,
  input  ex_pkg::word_t  ex_c,
  output ex_pkg::word_t  op_a,
  output ex_pkg::word_t  op_b,
  output logic [4:0]     count
);

  import ex_pkg::*;

  word_t mask;
  word_t b_sel;

  assign mask = size_mask(dsize);

  // immediates and the cmpxchg source come in on C
  assign b_sel = use_c_as_b ? ex_c : ex_b;

  // zero-extend from the data size so upper bits never leak into flags
  assign op_a = ex_a & mask;
  assign op_b = b_sel & mask;

  // count is masked to five bits regardless of size
  assign count = ex_c[4:0];

endmodule

/* alu_unit_ex.sv */
`timescale 1ns/1ps

module alu_unit_ex (
  input  ex_pkg::aluk_t  aluk,
  input  ex_pkg::dsize_t dsize,
  input  ex_pkg::word_t  op_a,
  input  ex_pkg::word_t  op_b,
  input  ex_pkg::flags_t flags_in,
  output ex_pkg::word_t  alu_result,
  output ex_pkg::flags_t alu_flags
);

  import ex_pkg::*;

  word_t       mask;
  logic [4:0]  msb;
  logic [5:0]  top;
  logic        cin;
  logic [32:0] add_raw;
  logic [32:0] sub_raw;
  logic [32:0] raw;
  logic        is_sub;
  logic        is_logic;
  word_t       res;
  logic        a_sign;
  logic        b_sign;
  logic        r_sign;
  logic        carry;
  logic        ovf;

  assign mask = size_mask(dsize);
  assign msb  = sign_pos(dsize);
  // first bit above the operand, where carry or borrow lands
  assign top  = {1'b0, msb} + 6'd1;

  assign cin = ((aluk == ALUK_ADC) || (aluk == ALUK_SBB)) & flags_in[FLAG_CF];

  // operands are already zero-extended, so bit [top] is carry out
  // and for subtracts the sign of the wide difference is the borrow
  assign add_raw = {1'b0, op_a} + {1'b0, op_b} + {32'd0, cin};
  assign sub_raw = {1'b0, op_a} - {1'b0, op_b} - {32'd0, cin};

  always_comb begin
    raw      = add_raw;
    is_sub   = 1'b0;
    is_logic = 1'b0;
    case (aluk)
      ALUK_ADD,
      ALUK_ADC: begin
        raw = add_raw;
      end
      ALUK_SUB,
      ALUK_SBB,
      ALUK_CMP: begin
        raw    = sub_raw;
        is_sub = 1'b1;
      end
      ALUK_OR: begin
        raw      = {1'b0, op_a | op_b};
        is_logic = 1'b1;
      end
      ALUK_AND: begin
        raw      = {1'b0, op_a & op_b};
        is_logic = 1'b1;
      end
      ALUK_XOR: begin
        raw      = {1'b0, op_a ^ op_b};
        is_logic = 1'b1;
      end
      default: begin
        raw = add_raw;
      end
    endcase
  end

  assign res    = raw[31:0] & mask;
  assign a_sign = op_a[msb];
  assign b_sign = op_b[msb];
  assign r_sign = res[msb];
  assign carry  = is_logic ? 1'b0 : raw[top];

  // signed overflow from the sign bits at the data size
  always_comb begin
    if (is_logic) begin
      ovf = 1'b0;
    end else if (is_sub) begin
      ovf = (a_sign != b_sign) && (r_sign != a_sign);
    end else begin
      ovf = (a_sign == b_sign) && (r_sign != a_sign);
    end
  end

  always_comb begin
    alu_flags          = flags_in;
    alu_flags[FLAG_CF] = carry;
    alu_flags[FLAG_PF] = ~^res[7:0];
    alu_flags[FLAG_ZF] = (res == '0);
    alu_flags[FLAG_SF] = r_sign;
    alu_flags[FLAG_OF] = ovf;
  end

  assign alu_result = res;

endmodule

/* shift_unit_ex.sv */
`timescale 1ns/1ps

module shift_unit_ex (
  input  ex_pkg::shk_t   shk,
  input  ex_pkg::dsize_t dsize,
  input  ex_pkg::word_t  op_a,
  input  logic [4:0]     count,
  input  ex_pkg::flags_t flags_in,
  output ex_pkg::word_t  sh_result,
  output ex_pkg::flags_t sh_flags
);

  import ex_pkg::*;

  word_t       mask;
  logic [4:0]  msb;
  logic [5:0]  top;
  word_t       a_sext;
  logic [63:0] shl_ext;
  logic [63:0] shr_ext;
  logic [63:0] sar_ext;
  word_t       res;
  logic        cf;
  logic        of_new;
  logic        shifting;

  assign mask = size_mask(dsize);
  assign msb  = sign_pos(dsize);
  assign top  = {1'b0, msb} + 6'd1;

  // sign-extend the sized operand so sar fills with the right bit
  assign a_sext = op_a[msb] ? (op_a | ~mask) : op_a;

  // widened shifts keep the last bit shifted out next to the result
  assign shl_ext = {32'd0, op_a} << count;
  assign shr_ext = {op_a, 32'd0} >> count;
  assign sar_ext = $signed({a_sext, 32'd0}) >>> count;

  assign shifting = (count != 5'd0) && (shk != SHK_PASS);

  always_comb begin
    res    = op_a;
    cf     = flags_in[FLAG_CF];
    of_new = flags_in[FLAG_OF];
    case (shk)
      SHK_SHL: begin
        res    = shl_ext[31:0] & mask;
        cf     = shl_ext[top];
        of_new = res[msb] ^ shl_ext[top];
      end
      SHK_SHR: begin
        res    = shr_ext[63:32];
        cf     = shr_ext[31];
        of_new = op_a[msb];
      end
      SHK_SAR: begin
        res    = sar_ext[63:32] & mask;
        cf     = sar_ext[31];
        of_new = 1'b0;
      end
      SHK_PASS: begin
        res = op_a;
      end
      default: begin
        res = op_a;
      end
    endcase
  end

  always_comb begin
    sh_result = op_a;
    sh_flags  = flags_in;
    if (shifting) begin
      sh_result         = res;
      sh_flags[FLAG_CF] = cf;
      sh_flags[FLAG_PF] = ~^res[7:0];
      sh_flags[FLAG_ZF] = (res == '0);
      sh_flags[FLAG_SF] = res[msb];
      // OF only defined for single-bit shifts, otherwise left as is
      if (count == 5'd1) begin
        sh_flags[FLAG_OF] = of_new;
      end
    end
  end

endmodule

/* result_select_ex.sv */
`timescale 1ns/1ps

module result_select_ex (
  input  logic           ex_v,
  input  logic           is_shift,
  input  logic           is_cmpxchg,
  input  logic           pass_a,
  input  logic           ld_gpr1,
  input  logic           ld_gpr2,
  input  logic           dcache_write,
  input  logic           jmp_stall,
  input  ex_pkg::aluk_t  aluk,
  input  ex_pkg::word_t  op_a,
  input  ex_pkg::word_t  ex_b,
  input  ex_pkg::word_t  ex_c,
  input  ex_pkg::word_t  alu_result,
  input  ex_pkg::word_t  sh_result,
  input  ex_pkg::flags_t alu_flags,
  input  ex_pkg::flags_t sh_flags,
  input  ex_pkg::flags_t flags_in,
  output ex_pkg::word_t  result_a,
  output ex_pkg::word_t  result_b,
  output ex_pkg::flags_t flags_out,
  output logic           eff_ld_gpr1,
  output logic           eff_ld_gpr2,
  output logic           eff_dcache_write,
  output logic           dep_v_ld_gpr1,
  output logic           dep_v_ld_gpr2,
  output logic           dep_v_dcache_write,
  output logic           jmp_stall_out
);

  import ex_pkg::*;

  always_comb begin
    if (pass_a) begin
      result_a  = op_a;
      flags_out = flags_in;
    end else if (is_shift) begin
      result_a  = sh_result;
      flags_out = sh_flags;
    end else begin
      result_a  = alu_result;
      flags_out = alu_flags;
    end
    result_b         = ex_b;
    eff_ld_gpr1      = ld_gpr1;
    eff_ld_gpr2      = ld_gpr2;
    eff_dcache_write = dcache_write;

    // cmpxchg runs as a compare, ZF says accumulator matched destination
    if (is_cmpxchg) begin
      if (alu_flags[FLAG_ZF]) begin
        result_a    = ex_c;
        eff_ld_gpr2 = 1'b0;
      end else begin
        // mismatch loads the destination value into the accumulator
        result_b         = op_a;
        eff_ld_gpr1      = 1'b0;
        eff_ld_gpr2      = 1'b1;
        eff_dcache_write = 1'b0;
      end
    end else if (aluk == ALUK_CMP) begin
      eff_ld_gpr1      = 1'b0;
      eff_dcache_write = 1'b0;
    end
  end

  // dependency tracking only sees valid micro-ops
  assign dep_v_ld_gpr1      = eff_ld_gpr1 & ex_v;
  assign dep_v_ld_gpr2      = eff_ld_gpr2 & ex_v;
  assign dep_v_dcache_write = eff_dcache_write & ex_v;
  assign jmp_stall_out      = jmp_stall & ex_v;

endmodule

/* ex_wb_latch.sv */
`timescale 1ns/1ps

module ex_wb_latch (
  input  logic           CLK,
  input  logic           rst_n,
  input  logic           wb_stall,
  input  logic           ex_v,
  input  ex_pkg::word_t  ex_neip,
  input  ex_pkg::word_t  result_a,
  input  ex_pkg::word_t  result_b,
  input  ex_pkg::flags_t flags_out,
  input  logic           eff_ld_gpr1,
  input  logic           eff_ld_gpr2,
  input  logic           eff_dcache_write,
  input  ex_pkg::reg_t   ex_dr1,
  input  ex_pkg::reg_t   ex_dr2,
  input  ex_pkg::dsize_t dsize,
  output logic           wb_v,
  output logic           wb_ld_gpr1,
  output logic           wb_ld_gpr2,
  output logic           wb_dcache_write,
  output logic           ld_latches,
  output ex_pkg::word_t  wb_neip,
  output ex_pkg::word_t  wb_result_a,
  output ex_pkg::word_t  wb_result_b,
  output ex_pkg::flags_t wb_flags,
  output ex_pkg::reg_t   wb_dr1,
  output ex_pkg::reg_t   wb_dr2,
  output ex_pkg::dsize_t wb_dsize
);

  // upstream holds its EX registers while WB stalls
  assign ld_latches = ~wb_stall;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      wb_v            <= 1'b0;
      wb_ld_gpr1      <= 1'b0;
      wb_ld_gpr2      <= 1'b0;
      wb_dcache_write <= 1'b0;
    end else if (ld_latches) begin
      wb_v            <= ex_v;
      // bubbles travel with no writes attached
      wb_ld_gpr1      <= eff_ld_gpr1 & ex_v;
      wb_ld_gpr2      <= eff_ld_gpr2 & ex_v;
      wb_dcache_write <= eff_dcache_write & ex_v;
    end
  end

  always_ff @(posedge CLK) begin
    if (ld_latches) begin
      wb_neip     <= ex_neip;
      wb_result_a <= result_a;
      wb_result_b <= result_b;
      wb_flags    <= flags_out;
      wb_dr1      <= ex_dr1;
      wb_dr2      <= ex_dr2;
      wb_dsize    <= dsize;
    end
  end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic           CLK,
  input  logic           rst_n,
  input  logic           ex_v,
  input  ex_pkg::word_t  ex_neip,
  input  ex_pkg::aluk_t  aluk,
  input  ex_pkg::shk_t   shk,
  input  logic           is_shift,
  input  logic           is_cmpxchg,
  input  logic           pass_a,
  input  logic           use_c_as_b,
  input  logic           ld_gpr1,
  input  logic           ld_gpr2,
  input  logic           dcache_write,
  input  logic           jmp_stall,
  input  ex_pkg::dsize_t dsize,
  input  ex_pkg::word_t  ex_a,
  input  ex_pkg::word_t  ex_b,
  input  ex_pkg::word_t  ex_c,
  input  ex_pkg::reg_t   ex_dr1,
  input  ex_pkg::reg_t   ex_dr2,
  input  ex_pkg::flags_t flags_in,
  input  logic           wb_stall,
  output logic           wb_v,
  output ex_pkg::word_t  wb_neip,
  output ex_pkg::word_t  wb_result_a,
  output ex_pkg::word_t  wb_result_b,
  output ex_pkg::flags_t wb_flags,
  output logic           wb_ld_gpr1,
  output logic           wb_ld_gpr2,
  output logic           wb_dcache_write,
  output ex_pkg::reg_t   wb_dr1,
  output ex_pkg::reg_t   wb_dr2,
  output ex_pkg::dsize_t wb_dsize,
  output logic           ld_latches,
  output logic           dep_v_ld_gpr1,
  output logic           dep_v_ld_gpr2,
  output logic           dep_v_dcache_write,
  output logic           jmp_stall_out
);

  import ex_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] count;
  word_t      alu_result;
  flags_t     alu_flags;
  word_t      sh_result;
  flags_t     sh_flags;
  word_t      result_a;
  word_t      result_b;
  flags_t     flags_out;
  logic       eff_ld_gpr1;
  logic       eff_ld_gpr2;
  logic       eff_dcache_write;

  operand_select_ex u_operand_select_ex (
    .use_c_as_b (use_c_as_b),
    .dsize      (dsize),
    .ex_a       (ex_a),
    .ex_b       (ex_b),
    .ex_c       (ex_c),
    .op_a       (op_a),
    .op_b       (op_b),
    .count      (count)
  );

  alu_unit_ex u_alu_unit_ex (
    .aluk       (aluk),
    .dsize      (dsize),
    .op_a       (op_a),
    .op_b       (op_b),
    .flags_in   (flags_in),
    .alu_result (alu_result),
    .alu_flags  (alu_flags)
  );

  shift_unit_ex u_shift_unit_ex (
    .shk       (shk),
    .dsize     (dsize),
    .op_a      (op_a),
    .count     (count),
    .flags_in  (flags_in),
    .sh_result (sh_result),
    .sh_flags  (sh_flags)
  );

  result_select_ex u_result_select_ex (
    .ex_v               (ex_v),
    .is_shift           (is_shift),
    .is_cmpxchg         (is_cmpxchg),
    .pass_a             (pass_a),
    .ld_gpr1            (ld_gpr1),
    .ld_gpr2            (ld_gpr2),
    .dcache_write       (dcache_write),
    .jmp_stall          (jmp_stall),
    .aluk               (aluk),
    .op_a               (op_a),
    .ex_b               (ex_b),
    .ex_c               (ex_c),
    .alu_result         (alu_result),
    .sh_result          (sh_result),
    .alu_flags          (alu_flags),
    .sh_flags           (sh_flags),
    .flags_in           (flags_in),
    .result_a           (result_a),
    .result_b           (result_b),
    .flags_out          (flags_out),
    .eff_ld_gpr1        (eff_ld_gpr1),
    .eff_ld_gpr2        (eff_ld_gpr2),
    .eff_dcache_write   (eff_dcache_write),
    .dep_v_ld_gpr1      (dep_v_ld_gpr1),
    .dep_v_ld_gpr2      (dep_v_ld_gpr2),
    .dep_v_dcache_write (dep_v_dcache_write),
    .jmp_stall_out      (jmp_stall_out)
  );

  ex_wb_latch u_ex_wb_latch (
    .CLK              (CLK),
    .rst_n            (rst_n),
    .wb_stall         (wb_stall),
    .ex_v             (ex_v),
    .ex_neip          (ex_neip),
    .result_a         (result_a),
    .result_b         (result_b),
    .flags_out        (flags_out),
    .eff_ld_gpr1      (eff_ld_gpr1),
    .eff_ld_gpr2      (eff_ld_gpr2),
    .eff_dcache_write (eff_dcache_write),
    .ex_dr1           (ex_dr1),
    .ex_dr2           (ex_dr2),
    .dsize            (dsize),
    .wb_v             (wb_v),
    .wb_ld_gpr1       (wb_ld_gpr1),
    .wb_ld_gpr2       (wb_ld_gpr2),
    .wb_dcache_write  (wb_dcache_write),
    .ld_latches       (ld_latches),
    .wb_neip          (wb_neip),
    .wb_result_a      (wb_result_a),
    .wb_result_b      (wb_result_b),
    .wb_flags         (wb_flags),
    .wb_dr1           (wb_dr1),
    .wb_dr2           (wb_dr2),
    .wb_dsize         (wb_dsize)
  );

endmodule

/* tb_execute_stage.sv */
`timescale 1ns/1ps

module tb_execute_stage;

  import ex_pkg::*;

  localparam int NUM_UOPS      = 3000;
  localparam int STALL_TIMEOUT = 64;

  logic   CLK;
  logic   rst_n;
  logic   ex_v;
  word_t  ex_neip;
  aluk_t  aluk;
  shk_t   shk;
  logic   is_shift, is_cmpxchg, pass_a, use_c_as_b;
  logic   ld_gpr1, ld_gpr2, dcache_write, jmp_stall;
  dsize_t dsize;
  word_t  ex_a, ex_b, ex_c;
  reg_t   ex_dr1, ex_dr2;
  flags_t flags_in;
  logic   wb_stall;
  logic   wb_v, wb_ld_gpr1, wb_ld_gpr2, wb_dcache_write;
  word_t  wb_neip, wb_result_a, wb_result_b;
  flags_t wb_flags;
  reg_t   wb_dr1, wb_dr2;
  dsize_t wb_dsize;
  logic   ld_latches;
  logic   dep_v_ld_gpr1, dep_v_ld_gpr2, dep_v_dcache_write, jmp_stall_out;

  // model outputs for the micro-op on the EX inputs
  word_t  m_ra, m_rb;
  flags_t m_flags;
  logic   m_g1, m_g2, m_dw;

  // expected WB record
  logic   exp_v, exp_g1, exp_g2, exp_dw;
  word_t  exp_neip, exp_ra, exp_rb;
  flags_t exp_flags;
  reg_t   exp_dr1, exp_dr2;
  dsize_t exp_ds;
  logic   data_known;

  execute_stage dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Fail %s expected %h actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  function automatic int width_of(input dsize_t ds);
    if (ds == DS_8) return 8;
    if (ds == DS_16) return 16;
    return 32;
  endfunction

  function automatic word_t low_bits(input word_t v, input dsize_t ds);
    int n;
    n = width_of(ds);
    if (n == 32) return v;
    return v & ((32'd1 << n) - 32'd1);
  endfunction

  function automatic longint signed_val(input word_t v, input int n);
    longint x;
    x = v;
    if (v[n-1]) x = x - (64'sd1 << n);
    return x;
  endfunction

  function automatic logic random_bit();
    int unsigned r;
    r = $urandom;
    return r[0];
  endfunction

  task automatic model_alu(output word_t r, output flags_t f);
    int     n;
    word_t  a, b;
    longint ua, ub, ur, sr, cin, lim;
    logic   cf, is_logic;
    n   = width_of(dsize);
    a   = low_bits(ex_a, dsize);
    b   = low_bits(use_c_as_b ? ex_c : ex_b, dsize);
    cin = ((aluk == ALUK_ADC || aluk == ALUK_SBB) && flags_in[FLAG_CF]) ? 1 : 0;
    ua  = a;
    ub  = b;
    sr  = 0;
    cf  = 1'b0;
    is_logic = 1'b0;
    case (aluk)
      ALUK_ADD, ALUK_ADC: begin
        ur = ua + ub + cin;
        cf = (ur >> n) != 0;
        sr = signed_val(a, n) + signed_val(b, n) + cin;
      end
      ALUK_SUB, ALUK_SBB, ALUK_CMP: begin
        ur = ua - ub - cin;
        cf = ua < (ub + cin);
        sr = signed_val(a, n) - signed_val(b, n) - cin;
      end
      ALUK_OR: begin
        ur = a | b;
        is_logic = 1'b1;
      end
      ALUK_AND: begin
        ur = a & b;
        is_logic = 1'b1;
      end
      default: begin
        ur = a ^ b;
        is_logic = 1'b1;
      end
    endcase
    r   = low_bits(ur[31:0], dsize);
    lim = 64'sd1 << (n - 1);
    f   = flags_in;
    f[FLAG_CF] = cf;
    f[FLAG_PF] = ~^r[7:0];
    f[FLAG_ZF] = (r == 32'd0);
    f[FLAG_SF] = r[n-1];
    f[FLAG_OF] = !is_logic && ((sr >= lim) || (sr < -lim));
  endtask

  // one bit per step, so the last bit out lands in cf
  task automatic model_shift(output word_t r, output flags_t f);
    int   n, cnt;
    logic cf, sgn;
    n   = width_of(dsize);
    cnt = ex_c[4:0];
    r   = low_bits(ex_a, dsize);
    sgn = r[n-1];
    f   = flags_in;
    cf  = flags_in[FLAG_CF];
    if (cnt != 0 && shk != SHK_PASS) begin
      for (int i = 0; i < cnt; i++) begin
        if (shk == SHK_SHL) begin
          cf = r[n-1];
          r  = low_bits(r << 1, dsize);
        end else begin
          cf = r[0];
          r  = r >> 1;
          if (shk == SHK_SAR) r[n-1] = sgn;
        end
      end
      f[FLAG_CF] = cf;
      f[FLAG_PF] = ~^r[7:0];
      f[FLAG_ZF] = (r == 32'd0);
      f[FLAG_SF] = r[n-1];
      if (cnt == 1) begin
        if (shk == SHK_SHL) f[FLAG_OF] = r[n-1] ^ cf;
        else if (shk == SHK_SHR) f[FLAG_OF] = sgn;
        else f[FLAG_OF] = 1'b0;
      end
    end
  endtask

  task automatic predict();
    word_t  ra_alu, ra_sh, a, b;
    flags_t f_alu, f_sh;
    model_alu(ra_alu, f_alu);
    model_shift(ra_sh, f_sh);
    a = low_bits(ex_a, dsize);
    b = low_bits(use_c_as_b ? ex_c : ex_b, dsize);
    m_rb = ex_b;
    m_g1 = ld_gpr1;
    m_g2 = ld_gpr2;
    m_dw = dcache_write;
    if (pass_a) begin
      m_ra    = a;
      m_flags = flags_in;
    end else if (is_shift) begin
      m_ra    = ra_sh;
      m_flags = f_sh;
    end else begin
      m_ra    = ra_alu;
      m_flags = f_alu;
    end
    if (is_cmpxchg) begin
      if (a == b) begin
        m_ra = ex_c;
        m_g2 = 1'b0;
      end else begin
        m_rb = a;
        m_g1 = 1'b0;
        m_g2 = 1'b1;
        m_dw = 1'b0;
      end
    end else if (aluk == ALUK_CMP) begin
      m_g1 = 1'b0;
      m_dw = 1'b0;
    end
  endtask

  task automatic randomize_uop();
    int unsigned kind, r;
    kind = $urandom % 8;
    r    = $urandom;
    ex_v = ($urandom % 10) < 8;
    ex_neip  = $urandom;
    aluk     = r[2:0];
    shk      = r[4:3];
    dsize    = dsize_t'($urandom % 3);
    ex_a     = $urandom;
    ex_b     = $urandom;
    ex_c     = $urandom;
    flags_in = $urandom;
    ex_dr1   = r[7:5];
    ex_dr2   = r[10:8];
    ld_gpr1      = random_bit();
    ld_gpr2      = random_bit();
    dcache_write = random_bit();
    jmp_stall    = random_bit();
    use_c_as_b   = random_bit();
    is_cmpxchg   = (kind == 0);
    is_shift     = (kind >= 1 && kind <= 3);
    pass_a       = (kind == 4);
    // counts of 0 and 1 need their own share
    if (r[12:11] == 2'd0) ex_c[4:0] = 5'd0;
    if (r[12:11] == 2'd1) ex_c[4:0] = 5'd1;
    if (is_cmpxchg) begin
      aluk       = ALUK_CMP;
      use_c_as_b = 1'b0;
      if (r[13]) ex_b = ex_a;
    end else if (r[16:14] == 3'd0) begin
      ex_b = ex_a;
    end
  endtask

  task automatic compare_wb();
    check_val("wb_v", exp_v, wb_v);
    check_val("wb_ld_gpr1", exp_g1, wb_ld_gpr1);
    check_val("wb_ld_gpr2", exp_g2, wb_ld_gpr2);
    check_val("wb_dcache_write", exp_dw, wb_dcache_write);
    if (data_known) begin
      check_val("wb_neip", exp_neip, wb_neip);
      check_val("wb_result_a", exp_ra, wb_result_a);
      check_val("wb_result_b", exp_rb, wb_result_b);
      check_val("wb_flags", exp_flags, wb_flags);
      check_val("wb_dr1", exp_dr1, wb_dr1);
      check_val("wb_dr2", exp_dr2, wb_dr2);
      check_val("wb_dsize", exp_ds, wb_dsize);
    end
  endtask

  initial begin
    logic accepted;
    int   waits;
    void'($urandom(32'h18315993));
    rst_n = 1'b0;
    wb_stall = 1'b0;
    ex_v = 1'b0;
    ex_neip = '0;
    aluk = '0;
    shk = '0;
    is_shift = 1'b0;
    is_cmpxchg = 1'b0;
    pass_a = 1'b0;
    use_c_as_b = 1'b0;
    ld_gpr1 = 1'b0;
    ld_gpr2 = 1'b0;
    dcache_write = 1'b0;
    jmp_stall = 1'b0;
    dsize = DS_32;
    ex_a = '0;
    ex_b = '0;
    ex_c = '0;
    ex_dr1 = '0;
    ex_dr2 = '0;
    flags_in = '0;
    exp_v = 1'b0;
    exp_g1 = 1'b0;
    exp_g2 = 1'b0;
    exp_dw = 1'b0;
    data_known = 1'b0;
    repeat (2) @(posedge CLK);
    #1;
    compare_wb();
    #1;
    rst_n = 1'b1;
    for (int k = 0; k < NUM_UOPS; k++) begin
      randomize_uop();
      predict();
      wb_stall = ($urandom % 5) == 0;
      accepted = 1'b0;
      waits = 0;
      // source holds the micro-op until the latch takes it
      while (!accepted) begin
        @(negedge CLK);
        check_val("dep_v_ld_gpr1", m_g1 & ex_v, dep_v_ld_gpr1);
        check_val("dep_v_ld_gpr2", m_g2 & ex_v, dep_v_ld_gpr2);
        check_val("dep_v_dcache_write", m_dw & ex_v, dep_v_dcache_write);
        check_val("jmp_stall_out", jmp_stall & ex_v, jmp_stall_out);
        check_val("ld_latches", !wb_stall, ld_latches);
        if (ld_latches) begin
          exp_v      = ex_v;
          exp_g1     = m_g1 & ex_v;
          exp_g2     = m_g2 & ex_v;
          exp_dw     = m_dw & ex_v;
          exp_neip   = ex_neip;
          exp_ra     = m_ra;
          exp_rb     = m_rb;
          exp_flags  = m_flags;
          exp_dr1    = ex_dr1;
          exp_dr2    = ex_dr2;
          exp_ds     = dsize;
          data_known = 1'b1;
          accepted   = 1'b1;
        end
        @(posedge CLK);
        #1;
        compare_wb();
        #1;
        if (!accepted) begin
          waits++;
          if (waits >= STALL_TIMEOUT) begin
            $display("timeout: ld_latches stayed low for %0d cycles", waits);
            stop_with_failure();
          end
          wb_stall = ($urandom % 5) == 0;
        end
      end
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* all.f */
ex_pkg.sv
operand_select_ex.sv
alu_unit_ex.sv
shift_unit_ex.sv
result_select_ex.sv
ex_wb_latch.sv
execute_stage.sv
tb_execute_stage.sv
